// File: src.f
+incdir+include
hw/stream_pkg.sv
hw/sram_array.sv
hw/wb_sram_interface.sv
hw/wb_sram_stream.sv
hw/stream_subsys_top.sv
verification/stream_tb.sv

// File: verification/stream_input.txt
# op sel wdata rdata wrap, hex. op: 0 read, 1 write, 2 reset. T starts a test
# rdata is dat_o with the ack (held word on writes), wrap is wrapped_o with the ack
T ring_fill_drain
1 3 0300 0000 0
1 3 1311 0000 0
1 3 2322 0000 0
1 3 3333 0000 0
1 3 4344 0000 0
1 3 5355 0000 0
1 3 6366 0000 0
1 3 7377 0000 0
1 3 8388 0000 0
1 3 9399 0000 0
1 3 A3AA 0000 0
1 3 B3BB 0000 0
1 3 C3CC 0000 0
1 3 D3DD 0000 0
1 3 E3EE 0000 0
1 3 F3FF 0000 1
0 0 0000 0300 0
0 0 0000 1311 0
0 0 0000 2322 0
0 0 0000 3333 0
0 0 0000 4344 0
0 0 0000 5355 0
0 0 0000 6366 0
0 0 0000 7377 0
0 0 0000 8388 0
0 0 0000 9399 0
0 0 0000 A3AA 0
0 0 0000 B3BB 0
0 0 0000 C3CC 0
0 0 0000 D3DD 0
0 0 0000 E3EE 0
0 0 0000 F3FF 1
T byte_lanes_reset
1 1 EE5C F3FF 0
1 2 7B99 F3FF 0
2 0 0000 0000 0
0 0 0000 035C 0
0 0 0000 7B11 0
T hold_and_wrap
1 3 C252 7B11 0
1 3 C353 7B11 0
1 3 C454 7B11 0
1 3 C555 7B11 0
1 3 C656 7B11 0
1 3 C757 7B11 0
1 3 C858 7B11 0
1 3 C959 7B11 0
1 3 CA5A 7B11 0
1 3 CB5B 7B11 0
1 3 CC5C 7B11 0
1 3 CD5D 7B11 0
1 3 CE5E 7B11 0
1 3 CF5F 7B11 1
0 0 0000 035C 0
0 0 0000 7B11 0
0 0 0000 C252 0

// File: verification/stream_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "stream_params.svh"

module stream_tb;

   import stream_pkg::*;

   localparam int DEPTH       = 1 << `STREAM_ADDR_W;  // SRAM words
   localparam int ACK_TIMEOUT = 20;                   // Cycles to wait for acks
   localparam int RST_CYCLES  = 16;                   // Mid-stream reset length

   // --------------------
   // DUT signals
   // --------------------
   logic  clk_i;
   logic  rst_i;
   logic  cyc_i;
   logic  stb_i;
   logic  we_i;
   sel_t  sel_i;
   data_t dat_i;
   logic  ack_o;
   logic  wrapped_o;
   data_t dat_o;

   // --------------------
   // Reference model and scoreboard
   // --------------------
   data_t model_mem [DEPTH];    // Byte-lane memory model
   addr_t model_addr;           // Next stream address
   data_t last_rd;              // Word dat_o should hold
   data_t held_dat;             // Word dat_o shows between acks
   data_t exp_dat_q [$];        // Expected dat_o per outstanding strobe
   logic  exp_wrap_q [$];       // Expected wrapped_o per strobe
   int    exp_cyc_q [$];        // Cycle in which the ack must show

   int    cycle_cnt = 0;        // Counts rising edges
   int    seed      = 32'h76b6;
   int    errors    = 0;
   int    strobes   = 0;
   int    acks      = 0;
   int    tests     = 0;
   bit    timed_out = 1'b0;

   // File parsing state
   int         fd;
   int         line_no;
   int         n_fields;
   string      line;
   string      test_name;
   bit         test_open;
   int         test_err0;       // Error count when the test began
   int         test_strb0;      // Strobe count when the test began
   logic [3:0] f_op;            // 0 read, 1 write, 2 reset
   sel_t       f_sel;
   data_t      f_wdat;
   data_t      f_rdat;
   logic       f_wrap;

   stream_subsys_top stream_subsys_top_inst (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .cyc_i     (cyc_i),
      .stb_i     (stb_i),
      .we_i      (we_i),
      .sel_i     (sel_i),
      .dat_i     (dat_i),
      .ack_o     (ack_o),
      .wrapped_o (wrapped_o),
      .dat_o     (dat_o)
   );

   always #5 clk_i = ~clk_i;                     // 10 ns period

   always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

   // --------------------
   // Compare tasks
   // --------------------
   task automatic check_data(input string sig, input data_t exp_v, input data_t act_v);
      if (act_v !== exp_v) begin
         errors++;
         $display("[FAIL] t=%0t %s expected %h got %h", $time, sig, exp_v, act_v);
      end
   endtask

   task automatic check_flag(input string sig, input logic exp_v, input logic act_v);
      if (act_v !== exp_v) begin
         errors++;
         $display("[FAIL] t=%0t %s expected %b got %b", $time, sig, exp_v, act_v);
      end
   endtask

   // --------------------
   // Bus driving
   // --------------------
   task automatic next_slot();
      @(posedge clk_i);
      #1;                                        // Drive just after the edge
   endtask

   task automatic idle_bus();
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
      sel_i = '0;
      dat_i = '0;
   endtask

   task automatic insert_gap();
      int r;
      int gaps;
      r    = $random(seed);
      gaps = (r[1:0] == 2'b00) ? 1 + r[2] : 0;   // Mostly back-to-back
      for (int g = 0; g < gaps; g++) begin
         r     = $random(seed);
         cyc_i = r[0];                           // Never cyc and stb together
         stb_i = ~r[0];
         we_i  = r[1];
         dat_i = r[31:16];                       // Junk, must be ignored
         next_slot();
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_dat_q.size() != 0 && waited < ACK_TIMEOUT) begin
         next_slot();
         waited++;
      end
      if (exp_dat_q.size() != 0) begin
         timed_out = 1'b1;
         errors++;
         $display("timeout: %0d strobe(s) got no ack within %0d cycles",
                  exp_dat_q.size(), ACK_TIMEOUT);
      end
   endtask

   task automatic issue_op(input logic wr, input sel_t sel, input data_t wdat,
                           input data_t file_dat, input logic file_wrap);
      data_t e_dat;
      logic  e_wrap;
      e_wrap = (model_addr == addr_t'(`STREAM_LAST));  // Last ring slot
      if (wr) begin
         for (int b = 0; b < `STREAM_BYTES; b++) begin
            if (sel[b]) model_mem[model_addr][b*8 +: 8] = wdat[b*8 +: 8];
         end
         e_dat = last_rd;                        // Writes keep the old word
      end else begin
         e_dat   = model_mem[model_addr];
         last_rd = e_dat;
      end
      if (e_dat !== file_dat || e_wrap !== file_wrap) begin
         errors++;
         $display("line %0d: file expects %h/%b but the model gives %h/%b",
                  line_no, file_dat, file_wrap, e_dat, e_wrap);
      end
      model_addr = e_wrap ? addr_t'(`STREAM_START) : model_addr + addr_t'(1);
      insert_gap();
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = wr;
      sel_i = sel;
      dat_i = wdat;
      exp_dat_q.push_back(e_dat);
      exp_wrap_q.push_back(e_wrap);
      exp_cyc_q.push_back(cycle_cnt + 1);        // Accepted on the next edge
      strobes++;
      next_slot();
      idle_bus();                                // Next op may override
   endtask

   task automatic pulse_reset();
      wait_drain();
      rst_i = 1'b1;
      cyc_i = 1'b1;                              // Reads keep strobing in reset
      stb_i = 1'b1;
      for (int c = 0; c < RST_CYCLES; c++) begin
         next_slot();
         @(negedge clk_i);
         check_flag("ack_o", 1'b0, ack_o);
         check_flag("wrapped_o", 1'b0, wrapped_o);
         check_data("dat_o", '0, dat_o);
      end
      next_slot();
      idle_bus();
      rst_i      = 1'b0;
      model_addr = addr_t'(`STREAM_START);       // Counter restarts
      last_rd    = '0;                           // Hold register cleared
   endtask

   task automatic finish_test();
      wait_drain();
      $display("test %s: %0d transfers, %0d errors", test_name,
               strobes - test_strb0, errors - test_err0);
      tests++;
      test_open = 1'b0;
   endtask

   // --------------------
   // Ack monitor
   // --------------------
   // Outputs settle after the rising edge, so look at them mid-cycle
   always @(negedge clk_i) begin
      if (rst_i) begin
         held_dat = '0;                          // Hold register clears
      end else begin
         if (ack_o) begin
            if (exp_dat_q.size() == 0) begin
               errors++;
               $display("t=%0t: ack_o went high with no strobe outstanding", $time);
            end else begin
               if (exp_cyc_q[0] != cycle_cnt) begin
                  errors++;
                  $display("t=%0t: ack for the strobe accepted in cycle %0d came in cycle %0d",
                           $time, exp_cyc_q[0], cycle_cnt);
               end
               check_data("dat_o", exp_dat_q[0], dat_o);
               check_flag("wrapped_o", exp_wrap_q[0], wrapped_o);
               held_dat = exp_dat_q[0];
               void'(exp_dat_q.pop_front());
               void'(exp_wrap_q.pop_front());
               void'(exp_cyc_q.pop_front());
               acks++;
            end
         end else begin
            check_flag("wrapped_o", 1'b0, wrapped_o);  // Pulse only with ack
            check_data("dat_o", held_dat, dat_o);      // Word held when idle
         end
      end
   end

   // --------------------
   // Stimulus from file
   // --------------------
   initial begin
      clk_i = 1'b0;
      rst_i = 1'b1;
      idle_bus();
      model_addr = addr_t'(`STREAM_START);
      last_rd    = '0;
      test_open  = 1'b0;
      line_no    = 0;
      repeat (16) @(posedge clk_i);
      #1;
      rst_i = 1'b0;

      fd = $fopen("verification/stream_input.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("could not open verification/stream_input.txt");
      end else begin
         while (!timed_out && $fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() >= 2 && line[0] != "#") begin
               if (line[0] == "T") begin              // New test section
                  if (test_open) finish_test();
                  test_name  = line.substr(2, line.len() - 2);
                  test_open  = 1'b1;
                  test_err0  = errors;
                  test_strb0 = strobes;
               end else begin
                  n_fields = $sscanf(line, "%h %h %h %h %h",
                                     f_op, f_sel, f_wdat, f_rdat, f_wrap);
                  if (n_fields != 5 || f_op > 2) begin
                     errors++;
                     $display("line %0d: cannot parse the operation", line_no);
                  end else if (f_op == 2) begin
                     pulse_reset();
                  end else begin
                     issue_op(f_op[0], f_sel, f_wdat, f_rdat, f_wrap);
                  end
               end
            end
         end
         if (test_open && !timed_out) finish_test();
         $fclose(fd);
      end

      $display("summary: %0d tests, %0d strobes, %0d acks, %0d errors",
               tests, strobes, acks, errors);
      if (errors == 0 && !timed_out) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/stream_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "stream_params.svh"

module stream_subsys_top (
   input  wire                 clk_i,
   input  wire                 rst_i,

   // Wishbone pipelined stream port
   input  wire                 cyc_i,
   input  wire                 stb_i,
   input  wire                 we_i,
   input  stream_pkg::sel_t    sel_i,
   input  stream_pkg::data_t   dat_i,
   output logic                ack_o,
   output logic                wrapped_o,  // Ring wrapped on this ack
   output stream_pkg::data_t   dat_o
);

   import stream_pkg::*;

   // --------------------
   // Stream port to SRAM
   // --------------------
   logic  sram_ce;   // Chip enable
   logic  sram_we;   // Write enable
   sel_t  sram_be;   // Byte enables
   addr_t sram_ad;   // Word address
   data_t sram_di;   // Write data
   data_t sram_do;   // Read data, one cycle after enable

   wb_sram_stream #(
      .START_ADDR (`STREAM_START),
      .LAST_ADDR  (`STREAM_LAST)
   ) wb_sram_stream_inst (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .cyc_i     (cyc_i),
      .stb_i     (stb_i),
      .we_i      (we_i),
      .sel_i     (sel_i),
      .dat_i     (dat_i),
      .ack_o     (ack_o),
      .dat_o     (dat_o),
      .wrapped_o (wrapped_o),
      .sram_ce_o (sram_ce),
      .sram_we_o (sram_we),
      .sram_be_o (sram_be),
      .sram_ad_o (sram_ad),
      .sram_di_o (sram_di),
      .sram_do_i (sram_do)
   );

   // --------------------
   // On-chip SRAM
   // --------------------
   sram_array sram_array_inst (
      .clk_i (clk_i),
      .ce_i  (sram_ce),
      .we_i  (sram_we),
      .be_i  (sram_be),
      .ad_i  (sram_ad),
      .di_i  (sram_di),
      .do_o  (sram_do)
   );

endmodule

`default_nettype wire

// File: hw/wb_sram_stream.sv
`timescale 1ns/1ps
`default_nettype none

`include "stream_params.svh"

module wb_sram_stream #(
   parameter stream_pkg::addr_t START_ADDR = `STREAM_START,  // First ring address
   parameter stream_pkg::addr_t LAST_ADDR  = `STREAM_LAST    // Wrap after this one
) (
   input  wire                 clk_i,
   input  wire                 rst_i,

   // Wishbone pipelined stream port, no address
   input  wire                 cyc_i,
   input  wire                 stb_i,
   input  wire                 we_i,
   input  stream_pkg::sel_t    sel_i,
   input  stream_pkg::data_t   dat_i,
   output logic                ack_o,
   output stream_pkg::data_t   dat_o,
   output logic                wrapped_o,  // Pulses with ack of last address

   // SRAM side
   output logic                sram_ce_o,
   output logic                sram_we_o,
   output stream_pkg::sel_t    sram_be_o,
   output stream_pkg::addr_t   sram_ad_o,
   output stream_pkg::data_t   sram_di_o,
   input  stream_pkg::data_t   sram_do_i
);

   import stream_pkg::*;

   addr_t adr_q;       // Address of the next transfer
   addr_t adr_nxt;     // Stepped or wrapped address
   logic  at_last_w;   // Current address ends the ring
   logic  acc_w;       // Strobe accepted, from the bridge
   logic  wrap_q;      // Wrap pulse, aligned with ack

   // --------------------
   // Address counter
   // --------------------
   assign at_last_w = (adr_q == LAST_ADDR);
   assign adr_nxt   = at_last_w ? START_ADDR : adr_q + addr_t'(1);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         adr_q <= START_ADDR;
      end else if (acc_w) begin
         adr_q <= adr_nxt;           // Step on every accepted strobe
      end
   end

   // --------------------
   // Wrap pulse
   // --------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wrap_q <= 1'b0;
      end else begin
         wrap_q <= acc_w & at_last_w;  // Same edge that registers ack
      end
   end

   assign wrapped_o = wrap_q;

   // --------------------
   // Wishbone to SRAM bridge
   // --------------------
   wb_sram_interface wb_sram_interface_inst (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .cyc_i     (cyc_i),
      .stb_i     (stb_i),
      .we_i      (we_i),
      .sel_i     (sel_i),
      .dat_i     (dat_i),
      .adr_i     (adr_q),       // Counter drives every transfer
      .ack_o     (ack_o),
      .acc_o     (acc_w),       // Back to the counter as increment
      .dat_o     (dat_o),
      .sram_ce_o (sram_ce_o),
      .sram_we_o (sram_we_o),
      .sram_be_o (sram_be_o),
      .sram_ad_o (sram_ad_o),
      .sram_di_o (sram_di_o),
      .sram_do_i (sram_do_i)
   );

endmodule

`default_nettype wire

// File: hw/wb_sram_interface.sv
`timescale 1ns/1ps
`default_nettype none

`include "stream_params.svh"

module wb_sram_interface (
   input  wire                 clk_i,
   input  wire                 rst_i,

   // Wishbone pipelined slave side
   input  wire                 cyc_i,
   input  wire                 stb_i,
   input  wire                 we_i,
   input  stream_pkg::sel_t    sel_i,
   input  stream_pkg::data_t   dat_i,
   input  stream_pkg::addr_t   adr_i,      // From the stream address counter
   output logic                ack_o,
   output logic                acc_o,      // Strobe accepted this cycle
   output stream_pkg::data_t   dat_o,

   // SRAM side
   output logic                sram_ce_o,
   output logic                sram_we_o,
   output stream_pkg::sel_t    sram_be_o,
   output stream_pkg::addr_t   sram_ad_o,
   output stream_pkg::data_t   sram_di_o,
   input  stream_pkg::data_t   sram_do_i
);

   import stream_pkg::*;

   logic  acc_w;      // Accepted strobe, no stall ever
   logic  ack_q;      // Ack one cycle after acceptance
   logic  rd_pend_q;  // Acked transfer in this cycle is a read
   data_t hold_q;     // Last completed read word

   // --------------------
   // Strobe acceptance
   // --------------------
   // Every cycle with cyc and stb high is taken; the slave never
   // stalls, so the master only throttles by dropping stb
   assign acc_w = cyc_i & stb_i;
   assign acc_o = acc_w;  // Tells the counter to step

   // --------------------
   // SRAM control
   // --------------------
   assign sram_ce_o = acc_w;           // Combinational from the strobe
   assign sram_we_o = acc_w & we_i;    // Write only on accepted strobe
   assign sram_be_o = sel_i;           // Lanes used on writes only
   assign sram_ad_o = adr_i;
   assign sram_di_o = dat_i;

   // --------------------
   // Ack pipeline
   // --------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_q     <= 1'b0;
         rd_pend_q <= 1'b0;
      end else begin
         ack_q     <= acc_w;            // One ack per accepted strobe
         rd_pend_q <= acc_w & ~we_i;    // SRAM word arrives with this ack
      end
   end

   assign ack_o = ack_q;

   // --------------------
   // Read-data hold
   // --------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         hold_q <= '0;                  // dat_o reads zero after reset
      end else if (rd_pend_q) begin
         hold_q <= sram_do_i;           // Capture as the read ack ends
      end
   end

   // During a read ack the SRAM output goes straight out, so the word
   // is on dat_o in the ack cycle; afterwards the hold register keeps it
   // through writes until the next read completes
   assign dat_o = rd_pend_q ? sram_do_i : hold_q;

endmodule

`default_nettype wire

// File: hw/sram_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "stream_params.svh"

module sram_array (
   input  wire                 clk_i,
   input  wire                 ce_i,   // Chip enable
   input  wire                 we_i,   // Write when high, read when low
   input  stream_pkg::sel_t    be_i,   // Byte lane enables
   input  stream_pkg::addr_t   ad_i,   // Word address
   input  stream_pkg::data_t   di_i,   // Write data
   output stream_pkg::data_t   do_o    // Registered read data
);

   import stream_pkg::*;

   localparam int DEPTH = 1 << `STREAM_ADDR_W;  // Words in the array

   data_t mem [DEPTH];                          // Storage, never reset
   data_t rd_q;                                 // Read output register

   // --------------------
   // Write port
   // --------------------
   always_ff @(posedge clk_i) begin
      if (ce_i && we_i) begin
         for (int b = 0; b < `STREAM_BYTES; b++) begin
            if (be_i[b]) begin
               mem[ad_i][b*8 +: 8] <= di_i[b*8 +: 8];  // Enabled lane only
            end
         end
      end
   end

   // --------------------
   // Read port
   // --------------------
   always_ff @(posedge clk_i) begin
      if (ce_i && !we_i) begin
         rd_q <= mem[ad_i];  // Valid the cycle after enable
      end
   end

   // Holds last read word during writes and idle cycles
   assign do_o = rd_q;

endmodule

`default_nettype wire

// File: hw/stream_pkg.sv
`default_nettype none

`include "stream_params.svh"

// Types shared by the RTL and the testbench checks
package stream_pkg;

   // --------------------
   // Width types
   // --------------------
   typedef logic [`STREAM_DATA_W-1:0] data_t;  // One data word
   typedef logic [`STREAM_ADDR_W-1:0] addr_t;  // One SRAM word address
   typedef logic [`STREAM_BYTES-1:0]  sel_t;   // Byte enables, one per lane

endpackage

`default_nettype wire

// File: include/stream_params.svh
`ifndef STREAM_PARAMS_SVH
`define STREAM_PARAMS_SVH

// --------------------
// Bus and memory widths
// --------------------
`define STREAM_DATA_W 16                   // Wishbone data width
`define STREAM_ADDR_W 6                    // SRAM word address, 64 words
`define STREAM_BYTES  (`STREAM_DATA_W / 8) // Byte lanes per word

// --------------------
// Default address ring
// --------------------
`define STREAM_START 0                     // First ring address
`define STREAM_LAST  15                    // Last ring address, then wrap

`endif
